// ==== tag_dir_config.svh ====
`ifndef TAG_DIR_CONFIG_SVH
`define TAG_DIR_CONFIG_SVH

// number of lines in the directory
`define DIR_DEPTH 8

// line number width, log2 of the depth
`define DIR_TAG_W 3

`define DIR_INDEX_W 6

`endif

// ==== tag_dir_pkg.sv ====
`default_nettype none

`include "tag_dir_config.svh"

package tag_dir_pkg;

    typedef logic [`DIR_TAG_W-1:0] tag_t;

    typedef logic [`DIR_INDEX_W-1:0] index_t;

    // list length, 0 up to the full depth
    typedef logic [`DIR_TAG_W:0] len_t;

    typedef enum logic [1:0] {
        ST_INVALID = 2'd0,
        ST_FETCH   = 2'd1,
        ST_VALID   = 2'd2,
        ST_DIRTY   = 2'd3
    } line_status_t;

    typedef enum logic [2:0] {
        CMD_RD    = 3'd0,
        CMD_WR    = 3'd1,
        CMD_ALLOC = 3'd2,
        CMD_FILL  = 3'd3,
        CMD_INVAL = 3'd4
    } dir_cmd_t;

endpackage

`default_nettype wire

// ==== hit_lookup.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "tag_dir_config.svh"

module hit_lookup
    import tag_dir_pkg::*;
(
    input  index_t       index,
    input  line_status_t line_status [`DIR_DEPTH],
    input  index_t       line_index [`DIR_DEPTH],
    output logic         hit,
    output tag_t         hit_tag
);

    logic [`DIR_DEPTH-1:0] match;

    // invalid lines keep a stale index, so they never match
    always_comb begin
        for (int i = 0; i < `DIR_DEPTH; i++) begin
            match[i] = (line_status[i] != ST_INVALID) && (line_index[i] == index);
        end
    end

    assign hit = |match;

    // highest matching line wins
    always_comb begin
        hit_tag = '0;
        for (int i = 0; i < `DIR_DEPTH; i++) begin
            if (match[i]) begin
                hit_tag = tag_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== line_state_table.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "tag_dir_config.svh"

module line_state_table
    import tag_dir_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         accept,
    input  dir_cmd_t     cmd,
    input  tag_t         target_tag,
    input  index_t       index,
    output line_status_t line_status [`DIR_DEPTH],
    output index_t       line_index [`DIR_DEPTH],
    output logic         applied
);

    line_status_t tgt_status;
    index_t       tgt_index;
    logic         tgt_live;
    logic         wr_hit;

    assign tgt_status = line_status[target_tag];
    assign tgt_index  = line_index[target_tag];
    assign tgt_live   = (tgt_status == ST_VALID) || (tgt_status == ST_DIRTY);

    // a miss still points at some line, so recheck the index
    assign wr_hit = tgt_live && (tgt_index == index);

    always_comb begin
        case (cmd)
            CMD_FILL:  applied = (tgt_status == ST_FETCH);
            CMD_INVAL: applied = tgt_live;
            default:   applied = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DIR_DEPTH; i++) begin
                line_status[i] <= ST_INVALID;
                line_index[i]  <= '0;
            end
        end else if (accept) begin
            case (cmd)
                CMD_WR: begin
                    if (wr_hit) begin
                        line_status[target_tag] <= ST_DIRTY;
                    end
                end
                CMD_ALLOC: begin
                    // victim may be dirty, requester writes it back from the response
                    line_status[target_tag] <= ST_FETCH;
                    line_index[target_tag]  <= index;
                end
                CMD_FILL: begin
                    if (applied) begin
                        line_status[target_tag] <= ST_VALID;
                    end
                end
                CMD_INVAL: begin
                    if (applied) begin
                        line_status[target_tag] <= ST_INVALID;
                        line_index[target_tag]  <= '0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // fetch lines are stalled by gnt, a write never lands on them
    assert property (@(posedge clk) disable iff (!rst_n)
        accept && cmd == CMD_WR && tgt_index == index
        |-> tgt_status != ST_FETCH);

endmodule

`default_nettype wire

// ==== lru_link_table.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "tag_dir_config.svh"

module lru_link_table
    import tag_dir_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic hit_en,
    input  tag_t hit_tag,
    input  logic alloc_en,
    input  logic release_en,
    input  tag_t release_tag,
    output tag_t victim_tag,
    output logic victim_busy_ok
);

    tag_t prev_tag [`DIR_DEPTH];
    tag_t next_tag [`DIR_DEPTH];

    tag_t free_head;
    tag_t free_tail;
    len_t free_len;
    tag_t lru_head;
    tag_t lru_tail;
    len_t lru_len;

    logic free_empty;
    logic lru_empty;
    logic promote_en;
    tag_t promote_tag;

    assign free_empty = (free_len == '0);
    assign lru_empty  = (lru_len == '0);

    assign victim_busy_ok = !free_empty;
    assign victim_tag     = free_empty ? lru_tail : free_tail;

    // an allocate on a full directory recycles the LRU tail like a hit on it
    assign promote_en  = hit_en || (alloc_en && free_empty);
    assign promote_tag = hit_en ? hit_tag : lru_tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // one chain 0 -> 1 -> ... held entirely by the free list
            for (int i = 0; i < `DIR_DEPTH; i++) begin
                prev_tag[i] <= tag_t'(i - 1);
                next_tag[i] <= tag_t'(i + 1);
            end
            free_head <= '0;
            free_tail <= tag_t'(`DIR_DEPTH - 1);
            free_len  <= len_t'(`DIR_DEPTH);
            lru_head  <= '0;
            lru_tail  <= '0;
            lru_len   <= '0;
        end else if (promote_en) begin
            // nothing to do when already most recent
            if (promote_tag != lru_head) begin
                next_tag[promote_tag] <= lru_head;
                prev_tag[lru_head]    <= promote_tag;
                lru_head              <= promote_tag;
                if (promote_tag == lru_tail) begin
                    lru_tail <= prev_tag[promote_tag];
                end else begin
                    next_tag[prev_tag[promote_tag]] <= next_tag[promote_tag];
                    prev_tag[next_tag[promote_tag]] <= prev_tag[promote_tag];
                end
            end
        end else if (alloc_en) begin
            // pop the free tail
            free_len  <= free_len - 1'b1;
            free_tail <= prev_tag[free_tail];
            // push it on the lru head
            lru_len  <= lru_len + 1'b1;
            lru_head <= free_tail;
            if (lru_empty) begin
                lru_tail <= free_tail;
            end else begin
                next_tag[free_tail] <= lru_head;
                prev_tag[lru_head]  <= free_tail;
            end
        end else if (release_en) begin
            lru_len  <= lru_len - 1'b1;
            free_len <= free_len + 1'b1;
            if (release_tag == lru_head) begin
                lru_head <= next_tag[release_tag];
            end
            if (release_tag == lru_tail) begin
                lru_tail <= prev_tag[release_tag];
            end
            if (release_tag != lru_head && release_tag != lru_tail) begin
                next_tag[prev_tag[release_tag]] <= next_tag[release_tag];
                prev_tag[next_tag[release_tag]] <= prev_tag[release_tag];
            end
            // released line goes to the free head, allocated last
            free_head <= release_tag;
            if (free_empty) begin
                free_tail <= release_tag;
            end else begin
                next_tag[release_tag] <= free_head;
                prev_tag[free_head]   <= release_tag;
            end
        end
    end

    // every line sits on exactly one of the two lists
    assert property (@(posedge clk) disable iff (!rst_n)
        int'(free_len) + int'(lru_len) == `DIR_DEPTH);

endmodule

`default_nettype wire

// ==== access_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "tag_dir_config.svh"

module access_ctrl
    import tag_dir_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req,
    input  dir_cmd_t     cmd,
    input  index_t       index,
    input  tag_t         tag,
    input  logic         hit,
    input  tag_t         hit_tag,
    input  line_status_t line_status [`DIR_DEPTH],
    input  index_t       line_index [`DIR_DEPTH],
    input  tag_t         victim_tag,
    input  logic         victim_busy_ok,
    input  logic         applied,
    output logic         gnt,
    output logic         accept,
    output tag_t         target_tag,
    output logic         hit_en,
    output logic         alloc_en,
    output logic         release_en,
    output logic         rsp_valid,
    output logic         rsp_hit,
    output tag_t         rsp_tag,
    output line_status_t rsp_status,
    output index_t       rsp_index
);

    logic is_lookup;
    logic lookup_hit;

    assign is_lookup  = (cmd == CMD_RD) || (cmd == CMD_WR);
    assign lookup_hit = is_lookup && hit;

    // stall on anything still waiting for its fill
    always_comb begin
        gnt = 1'b1;
        if (cmd == CMD_ALLOC && !victim_busy_ok && line_status[victim_tag] == ST_FETCH) begin
            gnt = 1'b0;
        end else if (lookup_hit && line_status[hit_tag] == ST_FETCH) begin
            gnt = 1'b0;
        end
    end

    assign accept = req && gnt;

    always_comb begin
        case (cmd)
            CMD_RD, CMD_WR: target_tag = hit_tag;
            CMD_ALLOC:      target_tag = victim_tag;
            default:        target_tag = tag;
        endcase
    end

    assign hit_en     = accept && lookup_hit;
    assign alloc_en   = accept && (cmd == CMD_ALLOC);
    assign release_en = accept && (cmd == CMD_INVAL) && applied;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= accept;
        end
    end

    // values from before the update of this same edge
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_tag <= target_tag;
            if (is_lookup) begin
                rsp_hit    <= hit;
                rsp_status <= hit ? line_status[target_tag] : ST_INVALID;
                // equals the stored index on a hit
                rsp_index  <= index;
            end else begin
                rsp_hit    <= (cmd == CMD_ALLOC) || applied;
                rsp_status <= line_status[target_tag];
                rsp_index  <= line_index[target_tag];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) accept |=> rsp_valid);

    assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> $past(accept));

endmodule

`default_nettype wire

// ==== tag_dir_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "tag_dir_config.svh"

module tag_dir_top
    import tag_dir_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req,
    input  dir_cmd_t     cmd,
    input  index_t       index,
    input  tag_t         tag,
    output logic         gnt,
    output logic         rsp_valid,
    output logic         rsp_hit,
    output tag_t         rsp_tag,
    output line_status_t rsp_status,
    output index_t       rsp_index
);

    line_status_t line_status [`DIR_DEPTH];
    index_t       line_index [`DIR_DEPTH];
    logic         hit;
    tag_t         hit_tag;
    logic         applied;
    logic         accept;
    tag_t         target_tag;
    logic         hit_en;
    logic         alloc_en;
    logic         release_en;
    tag_t         victim_tag;
    logic         victim_busy_ok;

    hit_lookup hit_lookup_i (
        .index       (index),
        .line_status (line_status),
        .line_index  (line_index),
        .hit         (hit),
        .hit_tag     (hit_tag)
    );

    line_state_table line_state_table_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept      (accept),
        .cmd         (cmd),
        .target_tag  (target_tag),
        .index       (index),
        .line_status (line_status),
        .line_index  (line_index),
        .applied     (applied)
    );

    lru_link_table lru_link_table_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .hit_en         (hit_en),
        .hit_tag        (hit_tag),
        .alloc_en       (alloc_en),
        .release_en     (release_en),
        .release_tag    (target_tag),
        .victim_tag     (victim_tag),
        .victim_busy_ok (victim_busy_ok)
    );

    access_ctrl access_ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .cmd            (cmd),
        .index          (index),
        .tag            (tag),
        .hit            (hit),
        .hit_tag        (hit_tag),
        .line_status    (line_status),
        .line_index     (line_index),
        .victim_tag     (victim_tag),
        .victim_busy_ok (victim_busy_ok),
        .applied        (applied),
        .gnt            (gnt),
        .accept         (accept),
        .target_tag     (target_tag),
        .hit_en         (hit_en),
        .alloc_en       (alloc_en),
        .release_en     (release_en),
        .rsp_valid      (rsp_valid),
        .rsp_hit        (rsp_hit),
        .rsp_tag        (rsp_tag),
        .rsp_status     (rsp_status),
        .rsp_index      (rsp_index)
    );

endmodule

`default_nettype wire

// ==== tb_tag_dir.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_tag_dir;
    import tag_dir_pkg::*;

    localparam int MAX_REQ = 64;
    localparam int FIELDS  = 8;
    localparam int TIMEOUT = 20;

    logic         clk;
    logic         rst_n;
    logic         req;
    dir_cmd_t     cmd;
    index_t       index;
    tag_t         tag;
    logic         gnt;
    logic         rsp_valid;
    logic         rsp_hit;
    tag_t         rsp_tag;
    line_status_t rsp_status;
    index_t       rsp_index;

    // eight hex fields per request, layout in the data file header
    logic [7:0] stim [0:MAX_REQ*FIELDS-1];

    int   errors;
    int   timeouts;
    int   req_count;
    logic data_end;

    tag_dir_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .cmd        (cmd),
        .index      (index),
        .tag        (tag),
        .gnt        (gnt),
        .rsp_valid  (rsp_valid),
        .rsp_hit    (rsp_hit),
        .rsp_tag    (rsp_tag),
        .rsp_status (rsp_status),
        .rsp_index  (rsp_index)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        errors++;
        $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic run_request(input int base);
        logic [7:0] hold;
        logic [7:0] exp_hit;
        logic [7:0] exp_tag;
        logic [7:0] exp_status;
        logic [7:0] exp_index;
        logic       is_lookup;
        int         waited;
        int         i;
        hold       = stim[base+3];
        exp_hit    = stim[base+4];
        exp_tag    = stim[base+5];
        exp_status = stim[base+6];
        exp_index  = stim[base+7];
        is_lookup  = (stim[base] == CMD_RD) || (stim[base] == CMD_WR);
        @(posedge clk);
        #1;
        req   = 1'b1;
        cmd   = dir_cmd_t'(stim[base][2:0]);
        index = index_t'(stim[base+1]);
        tag   = tag_t'(stim[base+2]);
        if (hold != 8'h0) begin
            // stalled request, withdrawn once the hold count has passed
            for (i = 0; i < hold; i++) begin
                @(negedge clk);
                if (gnt !== 1'b0) begin
                    report_mismatch("gnt", 8'h0, {7'h0, gnt});
                end
            end
            @(posedge clk);
            #1;
            req = 1'b0;
            @(negedge clk);
            if (rsp_valid !== 1'b0) begin
                report_mismatch("rsp_valid", 8'h0, {7'h0, rsp_valid});
            end
        end else begin
            waited = 0;
            @(negedge clk);
            while (gnt !== 1'b1 && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (gnt !== 1'b1) begin
                timeouts++;
                $display("timeout: request %0d never got gnt", base / FIELDS);
                @(posedge clk);
                #1;
                req = 1'b0;
            end else begin
                @(posedge clk);
                #1;
                req    = 1'b0;
                waited = 0;
                @(negedge clk);
                while (rsp_valid !== 1'b1 && waited < TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                if (rsp_valid !== 1'b1) begin
                    timeouts++;
                    $display("timeout: request %0d got no response", base / FIELDS);
                end else begin
                    if ({7'h0, rsp_hit} !== exp_hit) begin
                        report_mismatch("rsp_hit", exp_hit, {7'h0, rsp_hit});
                    end
                    // a lookup miss names no line, only rsp_hit is defined
                    if (!(is_lookup && exp_hit == 8'h0)) begin
                        if ({5'h0, rsp_tag} !== exp_tag) begin
                            report_mismatch("rsp_tag", exp_tag, {5'h0, rsp_tag});
                        end
                        if ({6'h0, rsp_status} !== exp_status) begin
                            report_mismatch("rsp_status", exp_status, {6'h0, rsp_status});
                        end
                        if ({2'h0, rsp_index} !== exp_index) begin
                            report_mismatch("rsp_index", exp_index, {2'h0, rsp_index});
                        end
                    end
                    // response lasts a single cycle
                    @(negedge clk);
                    if (rsp_valid !== 1'b0) begin
                        report_mismatch("rsp_valid", 8'h0, {7'h0, rsp_valid});
                    end
                end
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        cmd       = CMD_RD;
        index     = '0;
        tag       = '0;
        errors    = 0;
        timeouts  = 0;
        req_count = 0;
        data_end  = 1'b0;
        $readmemh("tag_dir_testdata.txt", stim);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // free list full, so nothing can stall
        @(negedge clk);
        if (gnt !== 1'b1) begin
            report_mismatch("gnt", 8'h1, {7'h0, gnt});
        end
        if (rsp_valid !== 1'b0) begin
            report_mismatch("rsp_valid", 8'h0, {7'h0, rsp_valid});
        end
        while (!data_end) begin
            if (req_count >= MAX_REQ || $isunknown(stim[req_count*FIELDS])) begin
                errors++;
                $display("data file ends without the end marker");
                data_end = 1'b1;
            end else if (stim[req_count*FIELDS] == 8'hff) begin
                data_end = 1'b1;
            end else begin
                run_request(req_count * FIELDS);
                req_count++;
            end
        end
        if (req_count == 0) begin
            errors++;
            $display("no requests were read from the data file");
        end
        repeat (2) @(posedge clk);
        $display("requests %0d errors %0d timeouts %0d", req_count, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tag_dir_testdata.txt ====
// cmd index tag hold | rsp_hit rsp_tag rsp_status rsp_index, all hex
// cmd 0 rd 1 wr 2 alloc 3 fill 4 inval, hold n expects gnt low n cycles, ff ends
// allocation order after reset
02 10 00 00 01 07 00 00
02 11 00 00 01 06 00 00
02 12 00 00 01 05 00 00
02 13 00 00 01 04 00 00
02 14 00 00 01 03 00 00
02 15 00 00 01 02 00 00
02 16 00 00 01 01 00 00
02 17 00 00 01 00 00 00
// stalls on lines in fetch
00 17 00 03 00 00 00 00
02 20 00 02 00 00 00 00
// fill every line
03 00 00 00 01 00 01 17
03 00 01 00 01 01 01 16
03 00 02 00 01 02 01 15
03 00 03 00 01 03 01 14
03 00 04 00 01 04 01 13
03 00 05 00 01 05 01 12
03 00 06 00 01 06 01 11
03 00 07 00 01 07 01 10
// lookup hit, write marks dirty, unknown index misses
00 10 00 00 01 07 02 10
01 10 00 00 01 07 02 10
00 10 00 00 01 07 03 10
00 3f 00 00 00 00 00 00
// touch line 6, victim is line 5
00 11 00 00 01 06 02 11
02 20 00 00 01 05 02 12
00 12 00 00 00 00 00 00
// invalidate and reuse
04 00 02 00 01 02 02 15
02 21 00 00 01 02 00 00
04 00 03 00 01 03 02 14
04 00 03 00 00 03 00 00
03 00 03 00 00 03 00 00
03 00 06 00 00 06 02 11
ff 00 00 00 00 00 00 00

// ==== all.f ====
+incdir+.
tag_dir_pkg.sv
hit_lookup.sv
line_state_table.sv
lru_link_table.sv
access_ctrl.sv
tag_dir_top.sv
tb_tag_dir.sv
